// ==== design/radio_pkg.sv ====
`default_nettype none

package radio_pkg;

   //////////////////////////////////////////////////
   // Stream and settings bus widths
   //////////////////////////////////////////////////
   localparam int DATA_W     = 64;
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;
   localparam int RB_SEL_W   = 3;

   // CHDR header fields
   localparam int TYPE_MSB = 63;
   localparam int TYPE_LSB = 62;
   localparam int SEQ_MSB  = 59;
   localparam int SEQ_LSB  = 48;
   localparam int SID_W    = 32;

   // Command payload with the setting data in the low word
   localparam int ADDR_MSB = 39;
   localparam int ADDR_LSB = 32;

   //////////////////////////////////////////////////
   // Setting addresses
   //////////////////////////////////////////////////
   localparam logic [SET_ADDR_W-1:0] SR_DACSYNC    = 8'd5;
   localparam logic [SET_ADDR_W-1:0] SR_TEST       = 8'd7;
   localparam logic [SET_ADDR_W-1:0] SR_MISC_OUTS  = 8'd24;
   localparam logic [SET_ADDR_W-1:0] SR_READBACK   = 8'd32;
   localparam logic [SET_ADDR_W-1:0] SR_TIME       = 8'd128;
   localparam logic [SET_ADDR_W-1:0] SR_CODEC_IDLE = 8'd250;

   typedef enum logic [1:0] {
      CHDR_DATA = 2'd0,
      CHDR_FC   = 2'd1,
      CHDR_CMD  = 2'd2,
      CHDR_RESP = 2'd3
   } chdr_type_e;

   // Gaps at 4 and 7 read back as zero
   typedef enum logic [RB_SEL_W-1:0] {
      RB_NONE      = 3'd0,
      RB_TIME      = 3'd1,
      RB_TIME_PPS  = 3'd2,
      RB_RX_TEST   = 3'd3,
      RB_TX_RX     = 3'd5,
      RB_RADIO_NUM = 3'd6
   } rb_sel_e;

   typedef enum logic [2:0] {
      CS_HDR,
      CS_PAYLOAD,
      CS_DRAIN,
      CS_WRITE,
      CS_RESP_HDR,
      CS_RESP_DATA
   } ctrl_state_e;

endpackage

`default_nettype wire

// ==== design/chdr_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module chdr_router
   import radio_pkg::*;
(
   input  logic              radio_clk,
   input  logic              i_arst_n,
   input  logic [DATA_W-1:0] i_in_tdata,
   input  logic              i_in_tlast,
   input  logic              i_in_tvalid,
   output logic              o_in_tready,
   output logic [DATA_W-1:0] o_cmd_tdata,
   output logic              o_cmd_tlast,
   output logic              o_cmd_tvalid,
   input  logic              i_cmd_tready
);

   logic       at_start;
   chdr_type_e pkt_type;
   chdr_type_e cur_type;
   logic       is_cmd;
   logic       in_xfer;

   // First beat carries the type, later beats use the latched copy
   assign cur_type = at_start ? chdr_type_e'(i_in_tdata[TYPE_MSB:TYPE_LSB]) : pkt_type;
   assign is_cmd   = (cur_type == CHDR_CMD);

   // Commands pass straight through
   assign o_cmd_tdata  = i_in_tdata;
   assign o_cmd_tlast  = i_in_tlast;
   assign o_cmd_tvalid = i_in_tvalid & is_cmd;

   // Everything else is swallowed one beat per cycle
   assign o_in_tready = is_cmd ? i_cmd_tready : 1'b1;
   assign in_xfer     = i_in_tvalid & o_in_tready;

   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         at_start <= 1'b1;
         pkt_type <= CHDR_DATA;
      end else if (in_xfer) begin
         at_start <= i_in_tlast;
         if (at_start) begin
            pkt_type <= cur_type;
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/radio_ctrl_proc.sv ====
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_proc
   import radio_pkg::*;
(
   input  logic                  radio_clk,
   input  logic                  i_arst_n,
   // Command stream from the router
   input  logic [DATA_W-1:0]     i_cmd_tdata,
   input  logic                  i_cmd_tlast,
   input  logic                  i_cmd_tvalid,
   output logic                  o_cmd_tready,
   // Settings bus
   output logic                  o_set_stb,
   output logic [SET_ADDR_W-1:0] o_set_addr,
   output logic [SET_DATA_W-1:0] o_set_data,
   input  logic [DATA_W-1:0]     i_rb_data,
   // Response stream
   output logic [DATA_W-1:0]     o_out_tdata,
   output logic                  o_out_tlast,
   output logic                  o_out_tvalid,
   input  logic                  i_out_tready
);

   ctrl_state_e              state;
   logic [SEQ_MSB-SEQ_LSB:0] seq_q;
   logic [SID_W-1:0]         sid_q;
   logic [DATA_W-1:0]        rb_q;
   logic                     cmd_xfer;
   logic                     out_xfer;
   logic [DATA_W-1:0]        resp_hdr;

   assign o_cmd_tready = (state == CS_HDR) || (state == CS_PAYLOAD) || (state == CS_DRAIN);
   assign cmd_xfer     = i_cmd_tvalid & o_cmd_tready;
   assign out_xfer     = o_out_tvalid & i_out_tready;

   // Length field holds the two-beat size in bytes
   assign resp_hdr = {CHDR_RESP, 2'b00, seq_q, 16'd16, sid_q};

   assign o_out_tvalid = (state == CS_RESP_HDR) || (state == CS_RESP_DATA);
   assign o_out_tlast  = (state == CS_RESP_DATA);
   assign o_out_tdata  = (state == CS_RESP_HDR) ? resp_hdr : rb_q;

   //////////////////////////////////////////////////
   // Command FSM
   //////////////////////////////////////////////////
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state     <= CS_HDR;
         o_set_stb <= 1'b0;
      end else begin
         o_set_stb <= 1'b0;
         case (state)
            CS_HDR: begin
               // A header alone has no setting to write
               if (cmd_xfer && !i_cmd_tlast) begin
                  state <= CS_PAYLOAD;
               end
            end
            CS_PAYLOAD: begin
               if (cmd_xfer) begin
                  if (i_cmd_tlast) begin
                     state     <= CS_WRITE;
                     o_set_stb <= 1'b1;
                  end else begin
                     state <= CS_DRAIN;
                  end
               end
            end
            CS_DRAIN: begin
               if (cmd_xfer && i_cmd_tlast) begin
                  state     <= CS_WRITE;
                  o_set_stb <= 1'b1;
               end
            end
            CS_WRITE: begin
               // Wait out the strobe cycle so readback sees the new settings
               if (!o_set_stb) begin
                  state <= CS_RESP_HDR;
               end
            end
            CS_RESP_HDR: begin
               if (out_xfer) begin
                  state <= CS_RESP_DATA;
               end
            end
            CS_RESP_DATA: begin
               if (out_xfer) begin
                  state <= CS_HDR;
               end
            end
            default: state <= CS_HDR;
         endcase
      end
   end

   // Header and payload fields and the readback word
   always_ff @(posedge radio_clk) begin
      if (cmd_xfer && state == CS_HDR) begin
         seq_q <= i_cmd_tdata[SEQ_MSB:SEQ_LSB];
         sid_q <= i_cmd_tdata[SID_W-1:0];
      end
      if (cmd_xfer && state == CS_PAYLOAD) begin
         o_set_addr <= i_cmd_tdata[ADDR_MSB:ADDR_LSB];
         o_set_data <= i_cmd_tdata[SET_DATA_W-1:0];
      end
      if (state == CS_WRITE && !o_set_stb) begin
         rb_q <= i_rb_data;
      end
   end

endmodule

`default_nettype wire

// ==== design/radio_settings.sv ====
`timescale 1ns/1ps
`default_nettype none

module radio_settings
   import radio_pkg::*;
#(
   parameter int unsigned RADIO_NUM = 0
) (
   input  logic                  radio_clk,
   input  logic                  i_arst_n,
   input  logic                  i_set_stb,
   input  logic [SET_ADDR_W-1:0] i_set_addr,
   input  logic [SET_DATA_W-1:0] i_set_data,
   input  logic [31:0]           i_rx,
   input  logic [DATA_W-1:0]     i_vita_time,
   input  logic [DATA_W-1:0]     i_vita_time_pps,
   output logic [DATA_W-1:0]     o_rb_data,
   output logic [31:0]           o_tx,
   output logic [7:0]            o_misc_outs,
   output logic                  o_sync_dacs
);

   logic [SET_DATA_W-1:0] test_reg;
   logic [SET_DATA_W-1:0] codec_idle;
   rb_sel_e               rb_sel;

   function automatic logic hit(input logic [SET_ADDR_W-1:0] addr);
      return i_set_stb && (i_set_addr == addr);
   endfunction

   //////////////////////////////////////////////////
   // Setting registers
   //////////////////////////////////////////////////
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         test_reg    <= '0;
         rb_sel      <= RB_NONE;
         o_misc_outs <= '0;
         codec_idle  <= '0;
      end else begin
         if (hit(SR_TEST)) begin
            test_reg <= i_set_data;
         end
         if (hit(SR_READBACK)) begin
            rb_sel <= rb_sel_e'(i_set_data[RB_SEL_W-1:0]);
         end
         if (hit(SR_MISC_OUTS)) begin
            o_misc_outs <= i_set_data[7:0];
         end
         if (hit(SR_CODEC_IDLE)) begin
            codec_idle <= i_set_data;
         end
      end
   end

   // Any write here fires one DAC sync pulse, data is ignored
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_sync_dacs <= 1'b0;
      end else begin
         o_sync_dacs <= hit(SR_DACSYNC);
      end
   end

   // No TX chain left, so the DAC always sees the idle word
   assign o_tx = codec_idle;

   //////////////////////////////////////////////////
   // Readback mux
   //////////////////////////////////////////////////
   always_comb begin
      case (rb_sel)
         RB_NONE:      o_rb_data = '0;
         RB_TIME:      o_rb_data = i_vita_time;
         RB_TIME_PPS:  o_rb_data = i_vita_time_pps;
         RB_RX_TEST:   o_rb_data = {i_rx, test_reg};
         RB_TX_RX:     o_rb_data = {o_tx, i_rx};
         RB_RADIO_NUM: o_rb_data = DATA_W'(RADIO_NUM);
         default:      o_rb_data = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== design/timekeeper.sv ====
`timescale 1ns/1ps
`default_nettype none

module timekeeper
   import radio_pkg::*;
(
   input  logic                  radio_clk,
   input  logic                  i_arst_n,
   input  logic                  i_pps,
   input  logic                  i_set_stb,
   input  logic [SET_ADDR_W-1:0] i_set_addr,
   input  logic [SET_DATA_W-1:0] i_set_data,
   output logic [DATA_W-1:0]     o_vita_time,
   output logic [DATA_W-1:0]     o_vita_time_pps
);

   logic [SET_DATA_W-1:0] time_hi;
   logic [1:0]            pps_sync;
   logic                  pps_d;
   logic                  pps_edge;
   logic                  load_hi;
   logic                  load_lo;

   // High word is staged, the low word write commits both
   assign load_hi = i_set_stb && (i_set_addr == SR_TIME);
   assign load_lo = i_set_stb && (i_set_addr == SR_TIME + 8'd1);

   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         time_hi     <= '0;
         o_vita_time <= '0;
      end else begin
         if (load_hi) begin
            time_hi <= i_set_data;
         end
         if (load_lo) begin
            o_vita_time <= {time_hi, i_set_data};
         end else begin
            o_vita_time <= o_vita_time + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // PPS capture
   //////////////////////////////////////////////////
   assign pps_edge = pps_sync[1] & ~pps_d;

   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pps_sync        <= '0;
         pps_d           <= 1'b0;
         o_vita_time_pps <= '0;
      end else begin
         pps_sync <= {pps_sync[0], i_pps};
         pps_d    <= pps_sync[1];
         if (pps_edge) begin
            o_vita_time_pps <= o_vita_time;
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/radio_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module radio_top
   import radio_pkg::*;
#(
   parameter int unsigned RADIO_NUM = 0
) (
   input  logic              radio_clk,
   input  logic              i_arst_n,
   // Packet input
   input  logic [DATA_W-1:0] i_in_tdata,
   input  logic              i_in_tlast,
   input  logic              i_in_tvalid,
   output logic              o_in_tready,
   // Packet output, responses only
   output logic [DATA_W-1:0] o_out_tdata,
   output logic              o_out_tlast,
   output logic              o_out_tvalid,
   input  logic              i_out_tready,
   // Radio pins
   input  logic [31:0]       i_rx,
   input  logic              i_pps,
   output logic [31:0]       o_tx,
   output logic [7:0]        o_misc_outs,
   output logic              o_sync_dacs
);

   logic [DATA_W-1:0]     cmd_tdata;
   logic                  cmd_tlast;
   logic                  cmd_tvalid;
   logic                  cmd_tready;

   logic                  set_stb;
   logic [SET_ADDR_W-1:0] set_addr;
   logic [SET_DATA_W-1:0] set_data;
   logic [DATA_W-1:0]     rb_data;
   logic [DATA_W-1:0]     vita_time;
   logic [DATA_W-1:0]     vita_time_pps;

   chdr_router router_i (
      .radio_clk    (radio_clk),
      .i_arst_n     (i_arst_n),
      .i_in_tdata   (i_in_tdata),
      .i_in_tlast   (i_in_tlast),
      .i_in_tvalid  (i_in_tvalid),
      .o_in_tready  (o_in_tready),
      .o_cmd_tdata  (cmd_tdata),
      .o_cmd_tlast  (cmd_tlast),
      .o_cmd_tvalid (cmd_tvalid),
      .i_cmd_tready (cmd_tready)
   );

   radio_ctrl_proc ctrl_i (
      .radio_clk    (radio_clk),
      .i_arst_n     (i_arst_n),
      .i_cmd_tdata  (cmd_tdata),
      .i_cmd_tlast  (cmd_tlast),
      .i_cmd_tvalid (cmd_tvalid),
      .o_cmd_tready (cmd_tready),
      .o_set_stb    (set_stb),
      .o_set_addr   (set_addr),
      .o_set_data   (set_data),
      .i_rb_data    (rb_data),
      .o_out_tdata  (o_out_tdata),
      .o_out_tlast  (o_out_tlast),
      .o_out_tvalid (o_out_tvalid),
      .i_out_tready (i_out_tready)
   );

   radio_settings #(.RADIO_NUM(RADIO_NUM)) settings_i (
      .radio_clk       (radio_clk),
      .i_arst_n        (i_arst_n),
      .i_set_stb       (set_stb),
      .i_set_addr      (set_addr),
      .i_set_data      (set_data),
      .i_rx            (i_rx),
      .i_vita_time     (vita_time),
      .i_vita_time_pps (vita_time_pps),
      .o_rb_data       (rb_data),
      .o_tx            (o_tx),
      .o_misc_outs     (o_misc_outs),
      .o_sync_dacs     (o_sync_dacs)
   );

   timekeeper timekeeper_i (
      .radio_clk       (radio_clk),
      .i_arst_n        (i_arst_n),
      .i_pps           (i_pps),
      .i_set_stb       (set_stb),
      .i_set_addr      (set_addr),
      .i_set_data      (set_data),
      .o_vita_time     (vita_time),
      .o_vita_time_pps (vita_time_pps)
   );

endmodule

`default_nettype wire

// ==== test/radio_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module radio_properties
   import radio_pkg::*;
(
   input logic              radio_clk,
   input logic              i_arst_n,
   input logic [DATA_W-1:0] o_out_tdata,
   input logic              o_out_tlast,
   input logic              o_out_tvalid,
   input logic              i_out_tready,
   input logic              o_sync_dacs,
   input logic [7:0]        o_misc_outs,
   input logic [31:0]       o_tx
);

   // Stalled output beat holds until accepted
   assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      o_out_tvalid && !i_out_tready |=>
         o_out_tvalid && $stable(o_out_tdata) && $stable(o_out_tlast))
      else $error("output beat changed or dropped while stalled");

   assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      o_sync_dacs |=> !o_sync_dacs)
      else $error("DAC sync pulse longer than one cycle");

   assert property (@(posedge radio_clk)
      !i_arst_n |-> (o_misc_outs == '0) && (o_tx == '0))
      else $error("misc outputs or tx not cleared in reset");

endmodule

bind radio_top radio_properties props_i (.*);

`default_nettype wire

// ==== test/radio_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module radio_tb
   import radio_pkg::*;
;

   localparam int          NUM        = 20;
   localparam int          MAX_CYCLES = 64 * NUM + 200;
   localparam logic [1:0]  CK_MASK    = 2'd0;
   localparam logic [1:0]  CK_TIME    = 2'd1;
   localparam logic [1:0]  CK_PPS     = 2'd2;
   localparam logic [63:0] ALL        = '1;
   localparam logic [31:0] RX_VAL     = 32'h1357_9BDF;
   localparam logic [31:0] TEST_A     = 32'hA5A5_1234;
   localparam logic [31:0] TEST_B     = 32'h0BAD_F00D;
   localparam logic [31:0] IDLE_W     = 32'hC0DE_0042;

   typedef struct packed {
      chdr_type_e  ptype;
      logic [3:0]  beats;
      logic [11:0] seq;
      logic [31:0] sid;
      logic [7:0]  addr;
      logic [31:0] data;
      logic        pps;
      logic        resp;
      logic [1:0]  kind;
      logic [63:0] exp;
      logic [63:0] mask;
   } entry_t;

   logic              radio_clk;
   logic              i_arst_n;
   logic [DATA_W-1:0] i_in_tdata;
   logic              i_in_tlast;
   logic              i_in_tvalid;
   logic              o_in_tready;
   logic [DATA_W-1:0] o_out_tdata;
   logic              o_out_tlast;
   logic              o_out_tvalid;
   logic              i_out_tready;
   logic [31:0]       i_rx;
   logic              i_pps;
   logic [31:0]       o_tx;
   logic [7:0]        o_misc_outs;
   logic              o_sync_dacs;

   entry_t      tbl [NUM];
   entry_t      e;
   integer      seed;
   int          n_add = 0;
   int          cycles = 0;
   int          sync_cnt = 0;
   int          out_beats = 0;
   int          exp_sync = 0;
   int          n_resp = 0;
   int          t_start = 0;
   logic [7:0]  exp_misc = '0;
   logic [31:0] exp_tx = '0;
   logic [31:0] time_hi = '0;
   logic [63:0] t_set = '0;
   logic [63:0] t_floor = '0;
   logic [63:0] rb;
   logic [63:0] elapsed;

   radio_top #(.RADIO_NUM(2)) dut_i (.*);

   initial begin
      radio_clk = 1'b0;
      forever #10 radio_clk = ~radio_clk;
   end

   // Random output back-pressure with ready about three cycles in four
   initial begin
      seed         = 16210;
      i_out_tready = 1'b0;
      forever begin
         @(posedge radio_clk);
         #2;
         i_out_tready = ($random(seed) & 3) != 0;
      end
   end

   always @(negedge radio_clk) begin
      if (o_sync_dacs) sync_cnt++;
      if (o_out_tvalid && i_out_tready) out_beats++;
   end

   always @(posedge radio_clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         stop_with_failure($sformatf("Timeout: run did not finish in %0d cycles", MAX_CYCLES));
      end
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////
   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp) else
         stop_with_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   // Strictly inside the open window (lo, hi)
   task automatic check_range(input string name, input logic [63:0] got,
                              input logic [63:0] lo, input logic [63:0] hi);
      assert (got > lo && got < hi) else
         stop_with_failure($sformatf("Fail %s: 0x%h not between 0x%h and 0x%h",
                                     name, got, lo, hi));
   endtask

   task automatic add_entry(input chdr_type_e ptype, input int beats, input logic [7:0] addr,
                            input logic [31:0] data, input logic pps, input logic [1:0] kind,
                            input logic [63:0] exp, input logic [63:0] mask);
      tbl[n_add] = '{ptype, 4'(beats), 12'h100 + 12'(n_add), 32'h0002_0000 + 32'(n_add * 3),
                     addr, data, pps, ptype == CHDR_CMD, kind, exp, mask};
      n_add++;
   endtask

   task automatic build_table();
      add_entry(CHDR_CMD, 2, SR_TEST, TEST_A, 0, CK_MASK, 64'd0, ALL);
      add_entry(CHDR_CMD, 2, SR_READBACK, 32'(RB_RX_TEST), 0, CK_MASK, {RX_VAL, TEST_A}, ALL);
      add_entry(CHDR_DATA, 3, 8'd0, 32'd0, 0, CK_MASK, 64'd0, 64'd0);
      add_entry(CHDR_CMD, 2, SR_MISC_OUTS, 32'h5C, 0, CK_MASK, {RX_VAL, TEST_A}, ALL);
      add_entry(CHDR_FC, 1, 8'd0, 32'd0, 0, CK_MASK, 64'd0, 64'd0);
      add_entry(CHDR_CMD, 2, SR_CODEC_IDLE, IDLE_W, 0, CK_MASK, {RX_VAL, TEST_A}, ALL);
      add_entry(CHDR_CMD, 2, SR_READBACK, 32'(RB_TX_RX), 0, CK_MASK, {IDLE_W, RX_VAL}, ALL);
      add_entry(CHDR_CMD, 4, SR_DACSYNC, 32'd0, 0, CK_MASK, {IDLE_W, RX_VAL}, ALL);
      add_entry(CHDR_RESP, 2, 8'd0, 32'd0, 0, CK_MASK, 64'd0, 64'd0);
      add_entry(CHDR_CMD, 2, SR_READBACK, 32'(RB_RADIO_NUM), 0, CK_MASK, 64'd2, ALL);
      add_entry(CHDR_CMD, 2, SR_READBACK, 32'd4, 0, CK_MASK, 64'd0, ALL);
      add_entry(CHDR_CMD, 2, SR_DACSYNC, 32'd1, 0, CK_MASK, 64'd0, ALL);
      add_entry(CHDR_CMD, 2, SR_TIME, 32'h1, 0, CK_MASK, 64'd0, ALL);
      add_entry(CHDR_CMD, 2, SR_TIME + 8'd1, 32'h100, 0, CK_MASK, 64'd0, ALL);
      add_entry(CHDR_CMD, 2, SR_READBACK, 32'(RB_TIME), 0, CK_TIME, 64'd0, 64'd0);
      add_entry(CHDR_CMD, 2, SR_READBACK, 32'(RB_TIME_PPS), 1, CK_PPS, 64'd0, 64'd0);
      add_entry(CHDR_CMD, 2, SR_READBACK, 32'(RB_TIME), 0, CK_TIME, 64'd0, 64'd0);
      add_entry(CHDR_CMD, 5, SR_TEST, TEST_B, 0, CK_TIME, 64'd0, 64'd0);
      add_entry(CHDR_CMD, 2, SR_READBACK, 32'(RB_RX_TEST), 0, CK_MASK, {RX_VAL, TEST_B}, ALL);
      add_entry(CHDR_DATA, 2, 8'd0, 32'd0, 0, CK_MASK, 64'd0, 64'd0);
   endtask

   //////////////////////////////////////////////////
   // Stream driver and response collector
   //////////////////////////////////////////////////
   task automatic send_beat(input logic [63:0] data, input logic last);
      @(posedge radio_clk);
      #2;
      i_in_tdata  = data;
      i_in_tlast  = last;
      i_in_tvalid = 1'b1;
      @(negedge radio_clk);
      while (!o_in_tready) @(negedge radio_clk);
   endtask

   task automatic send_packet(input entry_t p);
      logic [63:0] beat;
      int          k;
      send_beat({p.ptype, 2'b00, p.seq, 16'(8 * p.beats), p.sid}, p.beats == 1);
      for (k = 1; k < p.beats; k++) begin
         if (k == 1) beat = {24'd0, p.addr, p.data};
         else beat = {32'hFEED_0000, 16'(k), 4'h0, p.seq};
         send_beat(beat, k == p.beats - 1);
      end
      @(posedge radio_clk);
      #2;
      i_in_tvalid = 1'b0;
      i_in_tlast  = 1'b0;
   endtask

   task automatic wait_out_beat();
      @(negedge radio_clk);
      while (!(o_out_tvalid && i_out_tready)) @(negedge radio_clk);
   endtask

   task automatic collect_response(input entry_t p, output logic [63:0] data);
      logic [63:0] hdr;
      wait_out_beat();
      hdr = o_out_tdata;
      check_value("o_out_tlast on header", o_out_tlast, 1'b0);
      check_value("response type", hdr[TYPE_MSB:TYPE_LSB], CHDR_RESP);
      check_value("response seqnum", hdr[SEQ_MSB:SEQ_LSB], p.seq);
      check_value("response sid", hdr[SID_W-1:0], p.sid);
      wait_out_beat();
      data = o_out_tdata;
      check_value("o_out_tlast on data", o_out_tlast, 1'b1);
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////
   initial begin
      i_arst_n     = 1'b0;
      i_in_tdata   = '0;
      i_in_tlast   = 1'b0;
      i_in_tvalid  = 1'b0;
      i_rx         = RX_VAL;
      i_pps        = 1'b0;
      build_table();
      repeat (3) @(posedge radio_clk);
      #2;
      i_arst_n = 1'b1;

      for (int n = 0; n < NUM; n++) begin
         e = tbl[n];
         if (e.pps) begin
            @(posedge radio_clk);
            #2;
            i_pps = 1'b1;
            repeat (3) @(posedge radio_clk);
            #2;
            i_pps = 1'b0;
         end
         // Reference model of the settings side effects
         if (e.resp) begin
            case (e.addr)
               SR_MISC_OUTS:   exp_misc = e.data[7:0];
               SR_CODEC_IDLE:  exp_tx = e.data;
               SR_DACSYNC:     exp_sync++;
               SR_TIME:        time_hi = e.data;
               SR_TIME + 8'd1: begin
                  t_set   = {time_hi, e.data};
                  t_floor = t_set;
                  t_start = cycles;
               end
               default: ;
            endcase
         end
         send_packet(e);
         if (e.resp) begin
            collect_response(e, rb);
            n_resp++;
            elapsed = 64'(cycles - t_start);
            case (e.kind)
               CK_MASK: check_value("readback", rb & e.mask, e.exp & e.mask);
               CK_TIME: check_range("rb_time", rb, t_floor, t_set + elapsed);
               default: begin
                  check_range("rb_time_pps", rb, t_set, t_set + elapsed);
                  t_floor = rb;
               end
            endcase
            @(posedge radio_clk);
            #1;
            check_value("o_misc_outs", o_misc_outs, exp_misc);
            check_value("o_tx", o_tx, exp_tx);
            check_value("o_sync_dacs pulse count", sync_cnt, exp_sync);
            check_value("response beat count", out_beats, 2 * n_resp);
         end
      end

      // A response would raise valid two cycles after the last beat
      repeat (4) begin
         @(posedge radio_clk);
         #1;
         check_value("o_out_tvalid", o_out_tvalid, 1'b0);
      end
      check_value("response beat count", out_beats, 2 * n_resp);
      check_value("o_sync_dacs pulse count", sync_cnt, exp_sync);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/radio_pkg.sv
design/chdr_router.sv
design/radio_ctrl_proc.sv
design/radio_settings.sv
design/timekeeper.sv
design/radio_top.sv
test/radio_properties.sv
test/radio_tb.sv
